/* all.f */
verilog/video_timing_pkg.sv
verilog/sprite_pkg.sv
verilog/video_sync_counter.sv
verilog/video_sprite_ram.sv
verilog/sprite_host_port.sv
verilog/video_sprite_gen.sv
verilog/video_sprite_top.sv
tb/tb_video_sprite.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the sprite overlay testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing \
    --timescale 1ns/100ps \
    --top-module tb_video_sprite \
    -f all.f

status=0
./obj_dir/Vtb_video_sprite > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
fi
echo "run_sim: fail, simulator exit status ${status}"
exit 1

/* tb/sprite_vectors.txt */
# W <host addr hex> <data hex>    host write, addr bit 10 selects a register
# P <frame> <x> <y> <rgb hex>     expected pixel, frame counts vsync falls, x and y decimal
# F                               wait for the next vsync fall
# background, key colour, origin (100,50)
W 402 123
W 403 f0f
W 400 064
W 401 032
# sprite words at row*32+col
W 000 a5c
W 01f 3c7
W 043 f0f
W 0a5 e48
W 283 f0f
W 133 7e2
W 3e0 6b2
W 3ff 9d1
F
# frame 1, row 0 and the left and right bounds
P 1 99 50 123
P 1 100 50 a5c
P 1 131 50 3c7
P 1 132 50 123
# row 2 col 3 holds the key colour
P 1 103 52 123
P 1 105 55 e48
# origin staged mid frame, key change is immediate
W 400 0c8
W 401 096
W 403 001
P 1 103 70 f0f
P 1 100 81 6b2
P 1 131 81 9d1
P 1 100 82 123
F
# frame 2, origin (200,150)
P 2 100 50 123
P 2 200 150 a5c
P 2 231 181 9d1
# clipped origin (620,470)
W 400 26c
W 401 1d6
F
P 3 619 470 123
P 3 620 470 a5c
P 3 639 479 7e2

/* tb/tb_video_sprite.sv */
// run from the project root to find tb/sprite_vectors.txt; P lines must follow scan order in a frame
`timescale 1ns/100ps

module tb_video_sprite import video_timing_pkg::*, sprite_pkg::*; ();

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;
    // handshake delays counted from the edge that samples req
    localparam int ACK_RISE     = 2;
    localparam int ACK_FALL     = 1;
    localparam int HOST_TIMEOUT = 16;
    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);

    logic       clk = 1'b0;
    logic       rst;
    logic       host_req;
    host_addr_t host_addr;
    host_data_t host_wdata;
    logic       host_ack;
    rgb_t       rgb;
    logic       hsync;
    logic       vsync;
    logic       de;

    int seed       = 60660;
    int pix_checks = 0;

    // tracker state is only written at the falling edge
    int   cur_frame = 0;
    int   cur_x     = 0;
    int   cur_y     = -1;
    logic cur_de    = 1'b0;
    rgb_t cur_rgb   = '0;
    logic prev_hs   = 1'b1;
    logic prev_vs   = 1'b1;
    int   hs_low    = 0;

    always #HALF_PERIOD clk = ~clk;

    video_sprite_top video_sprite_top_i (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .rgb        (rgb),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de)
    );

    // --------------------------------------------------------------------------
    // compare tasks
    // --------------------------------------------------------------------------

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_coord(input string name, input h_coord_t exp, input h_coord_t act);
        if (act !== exp) begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    // --------------------------------------------------------------------------
    // screen position tracker
    // --------------------------------------------------------------------------

    // outputs are stable at the falling edge and the main flow reads at the rising edge
    always @(negedge clk) begin
        if (rst) begin
            cur_x   = 0;
            cur_y   = -1;
            cur_de  = 1'b0;
            prev_hs = 1'b1;
            prev_vs = 1'b1;
            hs_low  = 0;
        end else begin
            // vsync fall opens a new frame and the active lines follow the back porch
            if (prev_vs && !vsync) begin
                check_coord("active lines", h_coord_t'(V_DISPLAY), h_coord_t'(cur_y + 1));
                cur_frame = cur_frame + 1;
                cur_y     = -1;
            end
            if (de) begin
                // both syncs idle while pixels are shown
                check_bit("hsync", 1'b1, hsync);
                check_bit("vsync", 1'b1, vsync);
                if (!cur_de) begin
                    cur_y = cur_y + 1;
                    cur_x = 0;
                end else begin
                    cur_x = cur_x + 1;
                end
            end else if (cur_de) begin
                check_coord("de pixels per line", H_DISPLAY, h_coord_t'(cur_x + 1));
            end
            // black whenever de is low
            if (!de) begin
                check_rgb("rgb", '0, rgb);
            end
            // length of each hsync pulse
            if (!hsync) begin
                hs_low = hs_low + 1;
            end else if (!prev_hs) begin
                check_coord("hsync low cycles", H_SYNC, h_coord_t'(hs_low));
                hs_low = 0;
            end
            cur_de  = de;
            cur_rgb = rgb;
            prev_hs = hsync;
            prev_vs = vsync;
        end
    end

    // --------------------------------------------------------------------------
    // host driver and waits
    // --------------------------------------------------------------------------

    task automatic host_write(input host_addr_t addr, input host_data_t data);
        int waited;
        @(posedge clk);
        host_addr  <= addr;
        host_wdata <= data;
        host_req   <= 1'b1;
        // req is first sampled one edge after it is driven
        waited = 0;
        do begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > HOST_TIMEOUT) begin
                $display("host_ack never rose for a write to address 0x%h", addr);
                stop_run();
            end
        end while (host_ack !== 1'b1);
        check_coord("host_ack rise delay", h_coord_t'(ACK_RISE), h_coord_t'(waited - 2));
        @(posedge clk);
        host_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > HOST_TIMEOUT) begin
                $display("host_ack never fell after req dropped, address 0x%h", addr);
                stop_run();
            end
        end while (host_ack !== 1'b0);
        check_coord("host_ack fall delay", h_coord_t'(ACK_FALL), h_coord_t'(waited - 2));
    endtask

    task automatic fill_sprite_ram();
        for (int i = 0; i < SPRITE_DEPTH; i++) begin
            host_write(host_addr_t'(i), host_data_t'($random(seed)));
        end
    endtask

    task automatic wait_frame();
        int start;
        int waited;
        @(posedge clk);
        start  = cur_frame;
        waited = 0;
        while (cur_frame == start) begin
            @(posedge clk);
            waited = waited + 1;
            if (waited > FRAME_CYCLES + 1000) begin
                $display("no vsync falling edge within one frame time");
                stop_run();
            end
        end
    endtask

    task automatic check_pixel(input int frame, input int x, input int y, input rgb_t exp);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited = waited + 1;
            if (cur_frame > frame || waited > 2 * FRAME_CYCLES) begin
                $display("pixel (%0d,%0d) of frame %0d was never shown", x, y, frame);
                stop_run();
            end
        end while (!(cur_de === 1'b1 && cur_frame == frame && cur_y == y && cur_x == x));
        check_rgb($sformatf("rgb at (%0d,%0d)", x, y), exp, cur_rgb);
        pix_checks = pix_checks + 1;
    endtask

    // --------------------------------------------------------------------------
    // vector file
    // --------------------------------------------------------------------------

    task automatic skip_line(input int fd);
        int c;
        // 10 is the line feed
        do begin
            c = $fgetc(fd);
        end while (c != -1 && c != 10);
    endtask

    task automatic run_vectors();
        int         fd;
        int         c;
        int         n;
        logic [7:0] op;
        host_addr_t addr;
        host_data_t data;
        int         frame;
        int         x;
        int         y;
        rgb_t       exp_rgb;
        fd = $fopen("tb/sprite_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/sprite_vectors.txt");
            stop_run();
        end
        c = $fgetc(fd);
        while (c != -1) begin
            op = c[7:0];
            case (op)
                "#": skip_line(fd);
                "W": begin
                    n = $fscanf(fd, " %h %h", addr, data);
                    if (n != 2) begin
                        $display("malformed W line in the vector file");
                        stop_run();
                    end
                    host_write(addr, data);
                end
                "P": begin
                    n = $fscanf(fd, " %d %d %d %h", frame, x, y, exp_rgb);
                    if (n != 4) begin
                        $display("malformed P line in the vector file");
                        stop_run();
                    end
                    check_pixel(frame, x, y, exp_rgb);
                end
                "F": wait_frame();
                // blanks and line ends
                default: ;
            endcase
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------------------------------
    // main flow
    // --------------------------------------------------------------------------

    initial begin
        rst        <= 1'b1;
        host_req   <= 1'b0;
        host_addr  <= '0;
        host_wdata <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("host_ack", 1'b0, host_ack);
        // random words first and then the vector writes land on every checked pixel
        fill_sprite_ram();
        run_vectors();
        if (pix_checks > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("the vector file held no pixel checks");
            stop_run();
        end
    end

endmodule

/* verilog/sprite_host_port.sv */
// host must hold addr and data until ack falls; only the low 10 data bits reach x0 and y0
`timescale 1ns/100ps

module sprite_host_port import video_timing_pkg::*, sprite_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // four-phase req/ack host bus
    input  logic         host_req,
    input  host_addr_t   host_addr,
    input  host_data_t   host_wdata,
    output logic         host_ack,

    input  logic         frame_start,

    // sprite RAM write port
    output logic         ram_we,
    output sprite_addr_t ram_addr,
    output rgb_t         ram_din,

    // control registers
    output h_coord_t     x0,
    output v_coord_t     y0,
    output rgb_t         bg_rgb,
    output rgb_t         key_rgb
);

    host_state_t state;
    logic        is_reg;
    logic        reg_we;
    reg_off_t    reg_off;
    // origin staged by the host, copied to x0 and y0 between frames
    h_coord_t    x0_stage;
    v_coord_t    y0_stage;

    // --------------------------------------------------------------------------
    // handshake FSM
    // --------------------------------------------------------------------------

    // idle -> write for exactly one cycle -> wait for req to drop
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HOST_IDLE;
        end else begin
            case (state)
                HOST_IDLE: begin
                    if (host_req) begin
                        state <= HOST_WRITE;
                    end
                end
                HOST_WRITE: state <= HOST_WAIT_REL;
                HOST_WAIT_REL: begin
                    // a slow host parks the port here
                    if (!host_req) begin
                        state <= HOST_IDLE;
                    end
                end
                default: state <= HOST_IDLE;
            endcase
        end
    end

    // ack trails the state by one edge
    // rises 2 cycles after req is seen, falls 1 cycle after req drops
    always_ff @(posedge clk) begin
        if (rst) begin
            host_ack <= 1'b0;
        end else begin
            host_ack <= (state == HOST_WAIT_REL);
        end
    end

    // --------------------------------------------------------------------------
    // write decode
    // --------------------------------------------------------------------------

    // addr and data are held stable by the host for the whole transfer
    assign is_reg   = host_addr[HOST_REG_BIT];
    assign reg_off  = reg_off_t'(host_addr);
    assign ram_we   = (state == HOST_WRITE) && !is_reg;
    assign reg_we   = (state == HOST_WRITE) && is_reg;
    assign ram_addr = sprite_addr_t'(host_addr);
    assign ram_din  = rgb_t'(host_wdata);

    always_ff @(posedge clk) begin
        if (rst) begin
            x0_stage <= '0;
            y0_stage <= '0;
            x0       <= '0;
            y0       <= '0;
            bg_rgb   <= '0;
            key_rgb  <= '0;
        end else begin
            // colours apply at once, offsets past REG_KEY fall through
            if (reg_we) begin
                case (reg_off)
                    REG_X0:  x0_stage <= h_coord_t'(host_wdata);
                    REG_Y0:  y0_stage <= v_coord_t'(host_wdata);
                    REG_BG:  bg_rgb   <= rgb_t'(host_wdata);
                    REG_KEY: key_rgb  <= rgb_t'(host_wdata);
                    default: ;
                endcase
            end
            // new origin only between frames, no tearing
            if (frame_start) begin
                x0 <= x0_stage;
                y0 <= y0_stage;
            end
        end
    end

endmodule

/* verilog/sprite_pkg.sv */
// one 32x32 sprite in 12-bit colour; host bus is write only and register offsets above 3 are ignored
package sprite_pkg;

    // --------------------------------------------------------------------------
    // pixel and sprite geometry
    // --------------------------------------------------------------------------

    localparam int RGB_W = 12;
    // 4 bits each of red, green, blue with red in the top nibble
    typedef logic [RGB_W-1:0] rgb_t;

    localparam int SPRITE_HSIZE = 32;
    localparam int SPRITE_VSIZE = 32;
    // row stride in the RAM is a power of two so the multiply is a shift
    localparam int SPRITE_SHIFT = 5;

    localparam int SPRITE_AW    = 10;
    localparam int SPRITE_DEPTH = 1 << SPRITE_AW;
    typedef logic [SPRITE_AW-1:0] sprite_addr_t;

    // --------------------------------------------------------------------------
    // host bus and register map
    // --------------------------------------------------------------------------

    localparam int HOST_AW      = 11;
    // top address bit picks the register file over the sprite RAM
    localparam int HOST_REG_BIT = HOST_AW - 1;
    typedef logic [HOST_AW-1:0] host_addr_t;
    typedef logic [15:0]        host_data_t;

    // register offset, the low host address bits below the select bit
    typedef logic [HOST_REG_BIT-1:0] reg_off_t;
    localparam reg_off_t REG_X0  = 10'd0;
    localparam reg_off_t REG_Y0  = 10'd1;
    localparam reg_off_t REG_BG  = 10'd2;
    localparam reg_off_t REG_KEY = 10'd3;

    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_WRITE,
        HOST_WAIT_REL
    } host_state_t;

endpackage

/* verilog/video_sprite_gen.sv */
// needs a RAM with one cycle registered read on ram_addr_r; latency is 2 cycles and never stalls
`timescale 1ns/100ps

module video_sprite_gen import video_timing_pkg::*, sprite_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // position and sync from the counter
    input  h_coord_t     xx,
    input  v_coord_t     yy,
    input  logic         hsync,
    input  logic         vsync,
    input  logic         video_on,

    // control registers
    input  h_coord_t     x0,
    input  v_coord_t     y0,
    input  rgb_t         bg_rgb,
    input  rgb_t         key_rgb,

    // sprite RAM read port
    output sprite_addr_t ram_addr_r,
    input  rgb_t         ram_dout,

    // video out, all aligned
    output rgb_t         rgb,
    output logic         hsync_out,
    output logic         vsync_out,
    output logic         de
);

    // offsets from the origin, one extra bit so the top bit is the sign
    logic [$bits(h_coord_t):0] dx;
    logic [$bits(v_coord_t):0] dy;
    logic                      x_in;
    logic                      y_in;

    // stage 1 registers
    logic                      in_s1;
    logic                      on_s1;
    logic                      hs_s1;
    logic                      vs_s1;

    rgb_t                      pix_sel;

    // --------------------------------------------------------------------------
    // stage 1, region test and address
    // --------------------------------------------------------------------------

    assign dx = {1'b0, xx} - {1'b0, x0};
    assign dy = {1'b0, yy} - {1'b0, y0};

    // left of or above the origin shows up as a set sign bit
    assign x_in = !dx[$bits(h_coord_t)] && (h_coord_t'(dx) < h_coord_t'(SPRITE_HSIZE));
    assign y_in = !dy[$bits(v_coord_t)] && (v_coord_t'(dy) < v_coord_t'(SPRITE_VSIZE));

    // addr = row * 32 + col, the shift is bracketed so it binds before the add
    // the RAM read register acts as the stage 1 address register
    assign ram_addr_r = (sprite_addr_t'(dy[SPRITE_SHIFT-1:0]) << SPRITE_SHIFT)
                      + sprite_addr_t'(dx[SPRITE_SHIFT-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_s1 <= 1'b0;
            on_s1 <= 1'b0;
            hs_s1 <= 1'b1;
            vs_s1 <= 1'b1;
        end else begin
            in_s1 <= x_in && y_in;
            on_s1 <= video_on;
            hs_s1 <= hsync;
            vs_s1 <= vsync;
        end
    end

    // --------------------------------------------------------------------------
    // stage 2, blend with the RAM word
    // --------------------------------------------------------------------------

    // key colour punches a hole through to the background
    assign pix_sel = (in_s1 && (ram_dout != key_rgb)) ? ram_dout : bg_rgb;

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb       <= '0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            de        <= 1'b0;
        end else begin
            // black in blanking
            rgb       <= on_s1 ? pix_sel : '0;
            hsync_out <= hs_s1;
            vsync_out <= vs_s1;
            de        <= on_s1;
        end
    end

endmodule

/* verilog/video_sprite_ram.sv */
// contents are undefined until written; a read of the address being written returns the old word
`timescale 1ns/100ps

module video_sprite_ram import sprite_pkg::*; (
    input  logic         clk,

    // write port, from the host side
    input  logic         we,
    input  sprite_addr_t addr_w,
    input  rgb_t         din,

    // read port, dout valid the cycle after addr_r
    input  sprite_addr_t addr_r,
    output rgb_t         dout
);

    // one word per sprite pixel, row major
    rgb_t mem [SPRITE_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr_w] <= din;
        end
    end

    // registered read so this maps onto block RAM
    always_ff @(posedge clk) begin
        dout <= mem[addr_r];
    end

endmodule

/* verilog/video_sprite_top.sv */
// single clock domain; host writes obey the four-phase req/ack rules and video never waits on them
`timescale 1ns/100ps

module video_sprite_top import video_timing_pkg::*, sprite_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // host write bus
    input  logic       host_req,
    input  host_addr_t host_addr,
    input  host_data_t host_wdata,
    output logic       host_ack,

    // video out
    output rgb_t       rgb,
    output logic       hsync,
    output logic       vsync,
    output logic       de
);

    // --------------------------------------------------------------------------
    // interconnect
    // --------------------------------------------------------------------------

    // raw timing from the counter
    h_coord_t     xx;
    v_coord_t     yy;
    logic         hsync_raw;
    logic         vsync_raw;
    logic         video_on;
    logic         frame_start;

    // host side of the sprite RAM and registers
    logic         ram_we;
    sprite_addr_t ram_addr_w;
    rgb_t         ram_din;
    h_coord_t     x0;
    v_coord_t     y0;
    rgb_t         bg_rgb;
    rgb_t         key_rgb;

    // video side of the sprite RAM
    sprite_addr_t ram_addr_r;
    rgb_t         ram_dout;

    // --------------------------------------------------------------------------
    // instances
    // --------------------------------------------------------------------------

    video_sync_counter video_sync_counter_i (
        .clk         (clk),
        .rst         (rst),
        .xx          (xx),
        .yy          (yy),
        .hsync       (hsync_raw),
        .vsync       (vsync_raw),
        .video_on    (video_on),
        .frame_start (frame_start)
    );

    sprite_host_port sprite_host_port_i (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_ack    (host_ack),
        .frame_start (frame_start),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr_w),
        .ram_din     (ram_din),
        .x0          (x0),
        .y0          (y0),
        .bg_rgb      (bg_rgb),
        .key_rgb     (key_rgb)
    );

    // sits beside the generator so the host port can reach the write side
    video_sprite_ram video_sprite_ram_i (
        .clk    (clk),
        .we     (ram_we),
        .addr_w (ram_addr_w),
        .din    (ram_din),
        .addr_r (ram_addr_r),
        .dout   (ram_dout)
    );

    video_sprite_gen video_sprite_gen_i (
        .clk        (clk),
        .rst        (rst),
        .xx         (xx),
        .yy         (yy),
        .hsync      (hsync_raw),
        .vsync      (vsync_raw),
        .video_on   (video_on),
        .x0         (x0),
        .y0         (y0),
        .bg_rgb     (bg_rgb),
        .key_rgb    (key_rgb),
        .ram_addr_r (ram_addr_r),
        .ram_dout   (ram_dout),
        .rgb        (rgb),
        .hsync_out  (hsync),
        .vsync_out  (vsync),
        .de         (de)
    );

endmodule

/* verilog/video_sync_counter.sv */
// free running from reset with no enable; frame_start is high on the last count so the wrap edge loads
`timescale 1ns/100ps

module video_sync_counter import video_timing_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // current screen position, registered
    output h_coord_t xx,
    output v_coord_t yy,

    // sync and blanking, registered from the same count
    output logic     hsync,
    output logic     vsync,
    output logic     video_on,
    output logic     frame_start
);

    // --------------------------------------------------------------------------
    // next count
    // --------------------------------------------------------------------------

    h_coord_t h_next;
    v_coord_t v_next;
    logic     h_wrap;
    logic     v_wrap;

    assign h_wrap = (xx == H_LAST);
    assign v_wrap = (yy == V_LAST);

    always_comb begin
        h_next = xx + 10'd1;
        v_next = yy;
        if (h_wrap) begin
            h_next = '0;
            // the line count only moves at the end of a line
            if (v_wrap) begin
                v_next = '0;
            end else begin
                v_next = yy + 10'd1;
            end
        end
    end

    // --------------------------------------------------------------------------
    // registered outputs
    // --------------------------------------------------------------------------

    // every output is decoded from the next count
    // so all of them line up with xx and yy on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            xx          <= '0;
            yy          <= '0;
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            // (0,0) is visible
            video_on    <= 1'b1;
            frame_start <= 1'b0;
        end else begin
            xx          <= h_next;
            yy          <= v_next;
            hsync       <= ~((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
            vsync       <= ~((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
            video_on    <= (h_next < H_DISPLAY) && (v_next < V_DISPLAY);
            // high for the last pixel of the frame
            // so a copy made on this edge is live at (0,0)
            frame_start <= (h_next == H_LAST) && (v_next == V_LAST);
        end
    end

endmodule

/* verilog/video_timing_pkg.sv */
// fixed 640x480 at one pixel per clock with both sync pulses active low and no runtime change of mode
package video_timing_pkg;

    // --------------------------------------------------------------------------
    // coordinate types
    // --------------------------------------------------------------------------

    // pixel position along a line, wide enough for the full 800 count
    typedef logic [9:0] h_coord_t;
    // line position within a frame, wide enough for the full 525 count
    typedef logic [9:0] v_coord_t;

    // --------------------------------------------------------------------------
    // horizontal timing in pixels
    // --------------------------------------------------------------------------

    localparam h_coord_t H_DISPLAY    = 10'd640;
    localparam h_coord_t H_FRONT      = 10'd16;
    localparam h_coord_t H_SYNC       = 10'd96;
    localparam h_coord_t H_BACK       = 10'd48;
    localparam h_coord_t H_TOTAL      = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    // hsync low from 656 up to but not including 752
    localparam h_coord_t H_SYNC_START = H_DISPLAY + H_FRONT;
    localparam h_coord_t H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam h_coord_t H_LAST       = H_TOTAL - 10'd1;

    // --------------------------------------------------------------------------
    // vertical timing in lines
    // --------------------------------------------------------------------------

    localparam v_coord_t V_DISPLAY    = 10'd480;
    localparam v_coord_t V_FRONT      = 10'd10;
    localparam v_coord_t V_SYNC       = 10'd2;
    localparam v_coord_t V_BACK       = 10'd33;
    localparam v_coord_t V_TOTAL      = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
    localparam v_coord_t V_SYNC_START = V_DISPLAY + V_FRONT;
    localparam v_coord_t V_SYNC_END   = V_SYNC_START + V_SYNC;
    localparam v_coord_t V_LAST       = V_TOTAL - 10'd1;

endpackage
